/* verilog/chess_pkg.sv */
`default_nettype none

package chess_pkg;

    // piece kind in the low three bits of a square.
    typedef enum logic [2:0] {
        empty  = 3'd0,
        pawn   = 3'd1,
        bishop = 3'd2,
        knight = 3'd3,
        rook   = 3'd4,
        queen  = 3'd5,
        king   = 3'd6
    } piece_e;

    typedef enum logic {
        white = 1'b0,
        black = 1'b1
    } color_e;

    // an empty square is white with kind empty, so all zeros.
    typedef struct packed {
        color_e color;
        piece_e kind;
    } square_t;

    // row in [5:3], column in [2:0].
    typedef logic [5:0] square_addr_t;

    typedef square_t [63:0] board_t;

    typedef struct packed {
        logic left;
        logic right;
        logic up;
        logic down;
        logic center;
    } buttons_t;

    typedef struct packed {
        logic         valid;
        square_addr_t from;
        square_addr_t to;
    } move_cmd_t;

    typedef struct packed {
        logic         valid;
        square_addr_t addr;
    } selection_t;

    typedef enum logic {
        pick_piece  = 1'b0,
        pick_target = 1'b1
    } ctrl_state_e;

    // white king's pawn.
    localparam square_addr_t CURSOR_START = 6'd52;

    function automatic board_t start_board();
        board_t b;
        piece_e back [8];
        back = '{rook, knight, bishop, queen, king, bishop, knight, rook};
        b = '0;
        for (int col = 0; col < 8; col++) begin
            b[col]      = '{color: black, kind: back[col]};
            b[8 + col]  = '{color: black, kind: pawn};
            b[48 + col] = '{color: white, kind: pawn};
            b[56 + col] = '{color: white, kind: back[col]};
        end
        return b;
    endfunction

endpackage

`default_nettype wire

/* verilog/button_conditioner.sv */
`default_nettype none

module button_conditioner #(
    parameter int DEBOUNCE_CYCLES = 4
) (
    input  logic                clk,
    input  logic                rst,
    input  chess_pkg::buttons_t buttons,
    output chess_pkg::buttons_t presses
);
    import chess_pkg::*;

    localparam int NUM_BUTTONS = $bits(buttons_t);
    localparam int CNT_W = $clog2(DEBOUNCE_CYCLES + 1);

    logic [NUM_BUTTONS-1:0] raw;
    logic [NUM_BUTTONS-1:0] level;
    logic [NUM_BUTTONS-1:0] level_q;
    logic [CNT_W-1:0]       count [NUM_BUTTONS];

    assign raw = buttons;

    // a raw level that differs from the accepted one must hold for
    // DEBOUNCE_CYCLES samples before it is taken over.
    always_ff @(posedge clk) begin
        if (rst) begin
            level <= '0;
            for (int i = 0; i < NUM_BUTTONS; i++) begin
                count[i] <= '0;
            end
        end else begin
            for (int i = 0; i < NUM_BUTTONS; i++) begin
                if (raw[i] == level[i]) begin
                    count[i] <= '0;
                end else if (count[i] == CNT_W'(DEBOUNCE_CYCLES - 1)) begin
                    level[i] <= raw[i];
                    count[i] <= '0;
                end else begin
                    count[i] <= count[i] + CNT_W'(1);
                end
            end
        end
    end

    // one pulse per debounced rising edge.
    always_ff @(posedge clk) begin
        if (rst) begin
            level_q <= '0;
            presses <= '0;
        end else begin
            level_q <= level;
            presses <= level & ~level_q;
        end
    end

endmodule

`default_nettype wire

/* verilog/board_state.sv */
`default_nettype none

module board_state (
    input  logic                 clk,
    input  logic                 rst,
    input  chess_pkg::move_cmd_t move_cmd,
    output chess_pkg::board_t    board
);
    import chess_pkg::*;

    localparam square_t EMPTY_SQUARE = '{color: white, kind: empty};

    board_t next_board;

    // the mover overwrites whatever stood on the target, which is how a
    // capture happens.
    always_comb begin
        next_board = board;
        if (move_cmd.valid) begin
            next_board[move_cmd.to]   = board[move_cmd.from];
            next_board[move_cmd.from] = EMPTY_SQUARE;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            board <= start_board();
        end else begin
            board <= next_board;
        end
    end

endmodule

`default_nettype wire

/* verilog/move_controller.sv */
`default_nettype none

module move_controller (
    input  logic                    clk,
    input  logic                    rst,
    input  chess_pkg::buttons_t     presses,
    input  chess_pkg::board_t       board,
    output chess_pkg::square_addr_t cursor,
    output chess_pkg::selection_t   selection,
    output chess_pkg::color_e       turn,
    output chess_pkg::move_cmd_t    move_cmd
);
    import chess_pkg::*;

    ctrl_state_e state;
    logic [2:0]  row;
    logic [2:0]  col;
    square_t     under_cursor;
    logic        cursor_owned;

    assign row = cursor[5:3];
    assign col = cursor[2:0];

    assign under_cursor = board[cursor];
    assign cursor_owned = (under_cursor.kind != empty) && (under_cursor.color == turn);

    // up is toward row 0, black's side. edges clamp.
    always_ff @(posedge clk) begin
        if (rst) begin
            cursor <= CURSOR_START;
        end else if (presses.left) begin
            if (col != 3'd0) begin
                cursor <= cursor - 6'd1;
            end
        end else if (presses.right) begin
            if (col != 3'd7) begin
                cursor <= cursor + 6'd1;
            end
        end else if (presses.up) begin
            if (row != 3'd0) begin
                cursor <= cursor - 6'd8;
            end
        end else if (presses.down) begin
            if (row != 3'd7) begin
                cursor <= cursor + 6'd8;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= pick_piece;
            selection <= '0;
            turn      <= white;
            move_cmd  <= '0;
        end else begin
            move_cmd.valid <= 1'b0;
            if (presses.center) begin
                case (state)
                    pick_piece: begin
                        // only the side to move may pick up a piece.
                        if (cursor_owned) begin
                            selection <= '{valid: 1'b1, addr: cursor};
                            state     <= pick_target;
                        end
                    end
                    pick_target: begin
                        if (cursor == selection.addr) begin
                            selection <= '0;
                            state     <= pick_piece;
                        end else if (cursor_owned) begin
                            selection.addr <= cursor;
                        end else begin
                            // empty or enemy square, the piece goes there.
                            move_cmd  <= '{valid: 1'b1, from: selection.addr, to: cursor};
                            turn      <= (turn == white) ? black : white;
                            selection <= '0;
                            state     <= pick_piece;
                        end
                    end
                    default: begin
                        state <= pick_piece;
                    end
                endcase
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/chess_top.sv */
`default_nettype none

module chess_top #(
    parameter int DEBOUNCE_CYCLES = 4
) (
    input  logic                    clk,
    input  logic                    rst,
    input  chess_pkg::buttons_t     buttons,
    output chess_pkg::board_t       board,
    output chess_pkg::square_addr_t cursor,
    output chess_pkg::selection_t   selection,
    output chess_pkg::color_e       turn
);
    import chess_pkg::*;

    buttons_t  presses;
    move_cmd_t move_cmd;

    button_conditioner #(
        .DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)
    ) button_conditioner_inst (
        .clk    (clk),
        .rst    (rst),
        .buttons(buttons),
        .presses(presses)
    );

    move_controller move_controller_inst (
        .clk      (clk),
        .rst      (rst),
        .presses  (presses),
        .board    (board),
        .cursor   (cursor),
        .selection(selection),
        .turn     (turn),
        .move_cmd (move_cmd)
    );

    // board is read back by the controller for the ownership check.
    board_state board_state_inst (
        .clk     (clk),
        .rst     (rst),
        .move_cmd(move_cmd),
        .board   (board)
    );

endmodule

`default_nettype wire

/* dv/move_controller_checker.sv */
`default_nettype none

module move_controller_checker (
    input  logic                   clk,
    input  logic                   rst,
    input  chess_pkg::ctrl_state_e state,
    input  chess_pkg::selection_t  selection,
    input  chess_pkg::move_cmd_t   move_cmd
);
    import chess_pkg::*;

    // read by the testbench at the end of the run.
    int failures = 0;

    // a move is a single-cycle strobe.
    a_single_strobe: assert property (@(posedge clk) disable iff (rst)
        move_cmd.valid |=> !move_cmd.valid)
        else begin
            $error("move_cmd valid high for two cycles in a row");
            failures++;
        end

    a_selection_state: assert property (@(posedge clk) disable iff (rst)
        selection.valid == (state == pick_target))
        else begin
            $error("selection valid does not match the pick_target state");
            failures++;
        end

    a_distinct_squares: assert property (@(posedge clk) disable iff (rst)
        move_cmd.valid |-> move_cmd.from != move_cmd.to)
        else begin
            $error("move_cmd from and to are the same square");
            failures++;
        end

endmodule

bind move_controller move_controller_checker checker_inst (
    .clk      (clk),
    .rst      (rst),
    .state    (state),
    .selection(selection),
    .move_cmd (move_cmd)
);

`default_nettype wire

/* dv/chess_monitor.sv */
`default_nettype none

module chess_monitor (
    input  logic                    clk,
    input  chess_pkg::board_t       board,
    input  chess_pkg::square_addr_t cursor,
    input  chess_pkg::selection_t   selection,
    input  chess_pkg::color_e       turn,
    input  chess_pkg::buttons_t     step_buttons,
    output int                      error_count
);
    import chess_pkg::*;

    typedef struct packed {
        board_t       board;
        square_addr_t cursor;
        selection_t   selection;
        color_e       turn;
    } model_t;

    // the driver fires this once the last press has settled.
    event step_done;

    model_t model;
    string  test_name;
    int     test_errors;
    int     tests_run;
    int     tests_failed;
    int     total_errors;

    assign error_count = total_errors;

    // expected state after one press, built from row and column moves.
    function automatic model_t apply_press(input model_t m, input buttons_t b);
        model_t     n;
        logic [2:0] row;
        logic [2:0] col;
        square_t    sq;
        logic       owned;
        n = m;
        row = m.cursor[5:3];
        col = m.cursor[2:0];
        sq = m.board[m.cursor];
        owned = (sq.kind != empty) && (sq.color == m.turn);
        if (b.left && col != 3'd0) col = col - 3'd1;
        if (b.right && col != 3'd7) col = col + 3'd1;
        if (b.up && row != 3'd0) row = row - 3'd1;
        if (b.down && row != 3'd7) row = row + 3'd1;
        if (b.center) begin
            if (!m.selection.valid) begin
                if (owned) n.selection = '{valid: 1'b1, addr: m.cursor};
            end else if (m.cursor == m.selection.addr) begin
                n.selection = '0;
            end else if (owned) begin
                n.selection.addr = m.cursor;
            end else begin
                n.board[m.cursor] = m.board[m.selection.addr];
                n.board[m.selection.addr] = '{color: white, kind: empty};
                n.turn = (m.turn == white) ? black : white;
                n.selection = '0;
            end
        end
        n.cursor = {row, col};
        return n;
    endfunction

    task automatic note_mismatch();
        test_errors++;
        total_errors++;
    endtask

    task automatic compare_outputs();
        int bad_square;
        bad_square = -1;
        for (int i = 63; i >= 0; i--) begin
            if (board[i] != model.board[i]) bad_square = i;
        end
        if (bad_square >= 0) begin
            $display("Mismatch at %0t: board square %0d is %h, expected %h", $time,
                     bad_square, board[bad_square], model.board[bad_square]);
            note_mismatch();
        end
        if (cursor != model.cursor) begin
            $display("Mismatch at %0t: cursor is %0d, expected %0d", $time, cursor,
                     model.cursor);
            note_mismatch();
        end
        if (selection != model.selection) begin
            $display("Mismatch at %0t: selection is %b/%0d, expected %b/%0d", $time,
                     selection.valid, selection.addr, model.selection.valid,
                     model.selection.addr);
            note_mismatch();
        end
        if (turn != model.turn) begin
            $display("Mismatch at %0t: turn is %s, expected %s", $time, turn.name(),
                     model.turn.name());
            note_mismatch();
        end
    endtask

    task automatic start_test(input string name);
        test_name = name;
        test_errors = 0;
    endtask

    task automatic finish_test();
        tests_run++;
        if (test_errors == 0) begin
            $display("test %s: ok", test_name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d mismatches", test_name, test_errors);
        end
    endtask

    task automatic print_summary(input int assert_failures);
        $display("tests run %0d, tests failed %0d, mismatches %0d, assertion failures %0d",
                 tests_run, tests_failed, total_errors, assert_failures);
    endtask

    initial begin
        model = '{board: start_board(), cursor: CURSOR_START, selection: '0, turn: white};
        test_name = "none";
        test_errors = 0;
        tests_run = 0;
        tests_failed = 0;
        total_errors = 0;
        forever begin
            @(step_done);
            // outputs are stable at the falling edge.
            @(negedge clk);
            model = apply_press(model, step_buttons);
            compare_outputs();
        end
    end

endmodule

`default_nettype wire

/* dv/tb_chess.sv */
`default_nettype none

module tb_chess;
    import chess_pkg::*;

    localparam int DEBOUNCE_CYCLES = 4;
    localparam int PRESS_BUDGET = 200;
    localparam int WATCHDOG_CYCLES = PRESS_BUDGET * 3 * (DEBOUNCE_CYCLES + 8) + 200;

    localparam buttons_t BTN_LEFT   = 5'b10000;
    localparam buttons_t BTN_RIGHT  = 5'b01000;
    localparam buttons_t BTN_UP     = 5'b00100;
    localparam buttons_t BTN_DOWN   = 5'b00010;
    localparam buttons_t BTN_CENTER = 5'b00001;

    logic         clk;
    logic         rst;
    buttons_t     buttons;
    buttons_t     step_press;
    board_t       board;
    square_addr_t cursor;
    selection_t   selection;
    color_e       turn;
    int           error_count;
    int           assert_failures;

    chess_top #(
        .DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)
    ) chess_top_inst (
        .clk      (clk),
        .rst      (rst),
        .buttons  (buttons),
        .board    (board),
        .cursor   (cursor),
        .selection(selection),
        .turn     (turn)
    );

    chess_monitor monitor_inst (
        .clk         (clk),
        .board       (board),
        .cursor      (cursor),
        .selection   (selection),
        .turn        (turn),
        .step_buttons(step_press),
        .error_count (error_count)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired after %0d cycles, the tests did not complete",
                 WATCHDOG_CYCLES);
        $display("Simulation finished: FAIL");
        $finish;
    end

    // hand one settled step to the monitor and wait until it has compared.
    task automatic settle_step(input buttons_t b);
        step_press = b;
        -> monitor_inst.step_done;
        @(negedge clk);
        @(posedge clk);
    endtask

    task automatic press(input buttons_t b);
        @(posedge clk);
        buttons <= b;
        repeat (DEBOUNCE_CYCLES + 4) @(posedge clk);
        buttons <= '0;
        repeat (DEBOUNCE_CYCLES + 4) @(posedge clk);
        repeat (4) @(posedge clk);
        settle_step(b);
    endtask

    task automatic goto_square(input square_addr_t target);
        while (cursor[5:3] > target[5:3]) press(BTN_UP);
        while (cursor[5:3] < target[5:3]) press(BTN_DOWN);
        while (cursor[2:0] > target[2:0]) press(BTN_LEFT);
        while (cursor[2:0] < target[2:0]) press(BTN_RIGHT);
    endtask

    task automatic select_and_move(input square_addr_t from, input square_addr_t to);
        goto_square(from);
        press(BTN_CENTER);
        goto_square(to);
        press(BTN_CENTER);
    endtask

    task automatic random_press(input int choices);
        case ($urandom % choices)
            0: press(BTN_LEFT);
            1: press(BTN_RIGHT);
            2: press(BTN_UP);
            3: press(BTN_DOWN);
            default: press(BTN_CENTER);
        endcase
    endtask

    initial begin
        void'($urandom(30786));
        rst = 1'b1;
        buttons = '0;
        step_press = '0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);

        monitor_inst.start_test("reset_state");
        settle_step('0);
        monitor_inst.finish_test();

        // sweep into every edge, then wander.
        monitor_inst.start_test("cursor_clamp_and_walk");
        repeat (8) press(BTN_LEFT);
        repeat (8) press(BTN_UP);
        repeat (8) press(BTN_RIGHT);
        repeat (8) press(BTN_DOWN);
        repeat (40) random_press(4);
        monitor_inst.finish_test();

        monitor_inst.start_test("selection_rules");
        goto_square(6'd44);
        press(BTN_CENTER);
        goto_square(6'd12);
        press(BTN_CENTER);
        goto_square(6'd52);
        press(BTN_CENTER);
        press(BTN_CENTER);
        press(BTN_CENTER);
        goto_square(6'd51);
        press(BTN_CENTER);
        press(BTN_CENTER);
        monitor_inst.finish_test();

        monitor_inst.start_test("move_to_empty");
        select_and_move(6'd52, 6'd36);
        select_and_move(6'd11, 6'd27);
        monitor_inst.finish_test();

        monitor_inst.start_test("capture");
        select_and_move(6'd36, 6'd27);
        monitor_inst.finish_test();

        monitor_inst.start_test("random_game");
        repeat (60) random_press(6);
        monitor_inst.finish_test();

        assert_failures = chess_top_inst.move_controller_inst.checker_inst.failures;
        monitor_inst.print_summary(assert_failures);
        if (error_count == 0 && assert_failures == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* all.f */
verilog/chess_pkg.sv
verilog/button_conditioner.sv
verilog/board_state.sv
verilog/move_controller.sv
verilog/chess_top.sv
dv/move_controller_checker.sv
dv/chess_monitor.sv
dv/tb_chess.sv

/* run.sh */
#!/bin/sh
# Compile and run the chess testbench with Verilator.
# Exits non-zero unless the log holds the pass line.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    -f all.f \
    --top-module tb_chess \
    --Mdir obj_dir \
    -o sim_chess
status=$?
if [ $status -ne 0 ]; then
    echo "compile failed with status $status"
    exit 1
fi

./obj_dir/sim_chess +verilator+error+limit+1000 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^Simulation finished: PASS$" sim.log; then
    exit 0
fi
echo "pass line not found in sim.log"
exit 1
